/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module StoreTb

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module StoreTb -Mdir obj_dir
	out=$$(./obj_dir/VStoreTb); status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

/* rtl/StoreAgu.sv */
`timescale 1ns/1ps
`default_nettype none

module StoreAgu (
    input logic clk,
    input logic rst,
    input logic stall,
    input StorePkg::ModeFlags mode,
    input logic [63:0] regionMask,
    input StorePkg::BranchProv branch,
    input StorePkg::StoreUop uop,
    output StorePkg::AguOp aguOp,
    output StorePkg::ResUop resUop
);

    StorePkg::Word addrSum;
    StorePkg::Word addr;
    logic fault;
    StorePkg::Word genData;
    StorePkg::ByteMask genMask;
    StorePkg::ResFlags genFlags;
    logic accept;
    logic dropHeld;

    assign addrSum = uop.srcA + {{20{uop.imm[11]}}, uop.imm};
    assign addr = (uop.opcode >= StorePkg::SB_I) ? uop.srcA : addrSum;

    assign accept = uop.valid && !stall &&
        !(branch.taken && StorePkg::isYounger(uop.sqN, branch.sqN));
    assign dropHeld = aguOp.valid && branch.taken &&
        StorePkg::isYounger(aguOp.sqN, branch.sqN);

    always_comb begin
        case (uop.opcode)
            StorePkg::SB, StorePkg::SB_I: fault = (addr == '0);
            StorePkg::SH, StorePkg::SH_I: fault = (addr == '0) || addr[0];
            default: fault = (addr == '0) || (addr[1:0] != 2'b00);
        endcase
        // control register page
        if (addr[31:24] == 8'hFF && mode[StorePkg::MODE_NO_CREGS_WR]) begin
            fault = 1'b1;
        end
        // 64 MiB regions
        if (!regionMask[addr[31:26]] && mode[StorePkg::MODE_WMASK]) begin
            fault = 1'b1;
        end
    end

    always_comb begin
        genData = uop.srcB;
        genMask = 4'b1111;
        genFlags = StorePkg::NONE;
        case (uop.opcode)
            StorePkg::SB, StorePkg::SB_I: begin
                genData = uop.srcB << {addr[1:0], 3'b000};
                genMask = 4'b0001 << addr[1:0];
            end
            StorePkg::SH, StorePkg::SH_I: begin
                genData = addr[1] ? (uop.srcB << 16) : uop.srcB;
                genMask = addr[1] ? 4'b1100 : 4'b0011;
            end
            StorePkg::CBO_CLEAN: begin
                genData = 32'd0;
                genMask = 4'b0000;
            end
            StorePkg::CBO_INVAL: begin
                genData = 32'd1;
                genMask = 4'b0000;
                genFlags = StorePkg::ORDERING;
            end
            StorePkg::CBO_FLUSH: begin
                genData = 32'd2;
                genMask = 4'b0000;
                genFlags = StorePkg::ORDERING;
            end
            StorePkg::AMOADD: genData = uop.srcB + uop.srcC;
            StorePkg::AMOXOR: genData = uop.srcB ^ uop.srcC;
            StorePkg::AMOAND: genData = uop.srcB & uop.srcC;
            StorePkg::AMOOR: genData = uop.srcB | uop.srcC;
            StorePkg::AMOMIN: begin
                genData = ($signed(uop.srcB) < $signed(uop.srcC)) ? uop.srcB : uop.srcC;
            end
            StorePkg::AMOMAX: begin
                genData = ($signed(uop.srcB) < $signed(uop.srcC)) ? uop.srcC : uop.srcB;
            end
            StorePkg::AMOMINU: genData = (uop.srcB < uop.srcC) ? uop.srcB : uop.srcC;
            StorePkg::AMOMAXU: genData = (uop.srcB < uop.srcC) ? uop.srcC : uop.srcB;
            // word, SC and swap keep srcB with the full mask
            default: ;
        endcase
        if (fault) begin
            genFlags = StorePkg::ACCESS_FAULT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aguOp.valid <= 1'b0;
            resUop.valid <= 1'b0;
        end else begin
            resUop.valid <= accept;
            if (accept) begin
                aguOp.valid <= 1'b1;
                aguOp.addr <= addr;
                aguOp.data <= genData;
                aguOp.wmask <= genMask;
                aguOp.exception <= fault;
                aguOp.pc <= uop.pc;
                aguOp.sqN <= uop.sqN;

                resUop.tagDst <= (uop.opcode == StorePkg::SC_W) ?
                    StorePkg::TAG_DISCARD : uop.tagDst;
                resUop.nmDst <= (uop.opcode == StorePkg::SC_W) ? 5'd0 : uop.nmDst;
                resUop.sqN <= uop.sqN;
                resUop.pc <= uop.pc;
                resUop.flags <= genFlags;
                resUop.result <= addrSum;
            end else if (!stall || dropHeld) begin
                aguOp.valid <= 1'b0;
            end
        end
    end

    // each op reports once even while it is held
    assert property (@(posedge clk) disable iff (rst)
        resUop.valid |=> !resUop.valid || resUop.sqN != $past(resUop.sqN));

    // held op waits for the queue unless a branch kills it
    assert property (@(posedge clk) disable iff (rst) stall && !dropHeld |=> $stable(aguOp));

endmodule

`default_nettype wire

/* rtl/StorePkg.sv */
`default_nettype none

package StorePkg;

    typedef logic [31:0] Word;
    typedef logic [6:0] SqN;
    typedef logic [6:0] Tag;
    typedef logic [4:0] RegNm;
    typedef logic [3:0] ByteMask;
    typedef logic [1:0] ModeFlags;

    localparam int SQ_DEPTH = 4;
    localparam int SQ_PTR_W = $clog2(SQ_DEPTH);
    localparam int SQ_CNT_W = $clog2(SQ_DEPTH + 1);

    // result tag for a store-conditional whose value was already written at rename
    localparam Tag TAG_DISCARD = 7'h40;

    localparam int MODE_NO_CREGS_WR = 0;
    localparam int MODE_WMASK = 1;

    typedef logic [SQ_PTR_W-1:0] SqPtr;
    typedef logic [SQ_CNT_W-1:0] SqCnt;

    // opcodes from SB_I onward take srcA as the address
    typedef enum logic [4:0] {
        SB,
        SH,
        SW,
        SB_I,
        SH_I,
        SW_I,
        SC_W,
        CBO_CLEAN,
        CBO_INVAL,
        CBO_FLUSH,
        AMOSWAP,
        AMOADD,
        AMOXOR,
        AMOAND,
        AMOOR,
        AMOMIN,
        AMOMAX,
        AMOMINU,
        AMOMAXU
    } LsuOp;

    typedef enum logic [1:0] {
        NONE,
        ACCESS_FAULT,
        ORDERING
    } ResFlags;

    typedef struct packed {
        logic valid;
        LsuOp opcode;
        Word srcA;
        Word srcB;
        Word srcC;
        logic [11:0] imm;
        Word pc;
        Tag tagDst;
        RegNm nmDst;
        SqN sqN;
    } StoreUop;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchProv;

    typedef struct packed {
        logic valid;
        Word addr;
        Word data;
        ByteMask wmask;
        logic exception;
        Word pc;
        SqN sqN;
    } AguOp;

    typedef struct packed {
        logic valid;
        Tag tagDst;
        RegNm nmDst;
        SqN sqN;
        Word pc;
        ResFlags flags;
        Word result;
    } ResUop;

    typedef struct packed {
        logic valid;
        Word addr;
        Word data;
        ByteMask wmask;
        logic [1:0] cboOp;
    } MemWrite;

    // sequence numbers wrap, so age comes from the signed difference
    function automatic logic isYounger(SqN a, SqN b);
        return $signed(a - b) > 0;
    endfunction

endpackage

`default_nettype wire

/* rtl/StoreQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module StoreQueue (
    input logic clk,
    input logic rst,
    input StorePkg::AguOp aguOp,
    input StorePkg::BranchProv branch,
    input logic commit,
    output logic full,
    output StorePkg::MemWrite memWrite
);

    StorePkg::AguOp entries [StorePkg::SQ_DEPTH];
    logic [StorePkg::SQ_DEPTH-1:0] entryValid;
    logic [StorePkg::SQ_DEPTH-1:0] nextValid;
    logic [StorePkg::SQ_DEPTH-1:0] younger;
    StorePkg::SqPtr head;
    StorePkg::SqPtr tail;
    StorePkg::SqPtr wrPtr;
    StorePkg::SqCnt count;
    StorePkg::SqCnt keepCnt;
    logic push;
    logic pop;

    assign full = (count == StorePkg::SqCnt'(StorePkg::SQ_DEPTH));

    always_comb begin
        for (int i = 0; i < StorePkg::SQ_DEPTH; i++) begin
            younger[i] = branch.taken && entryValid[i] &&
                StorePkg::isYounger(entries[i].sqN, branch.sqN);
        end
    end

    // entries are in age order, so everything from the first younger one is flushed
    always_comb begin
        StorePkg::SqPtr idx;
        logic found;
        keepCnt = count;
        found = 1'b0;
        for (int i = 0; i < StorePkg::SQ_DEPTH; i++) begin
            idx = head + StorePkg::SqPtr'(i);
            if (!found && StorePkg::SqCnt'(i) < count && younger[idx]) begin
                keepCnt = StorePkg::SqCnt'(i);
                found = 1'b1;
            end
        end
    end

    assign wrPtr = branch.taken ? head + StorePkg::SqPtr'(keepCnt) : tail;
    assign push = aguOp.valid && !full &&
        !(branch.taken && StorePkg::isYounger(aguOp.sqN, branch.sqN));
    assign pop = commit && (keepCnt != '0);

    always_comb begin
        nextValid = entryValid & ~younger;
        if (pop) begin
            nextValid[head] = 1'b0;
        end
        if (push) begin
            nextValid[wrPtr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= aguOp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            entryValid <= '0;
            memWrite.valid <= 1'b0;
        end else begin
            head <= head + StorePkg::SqPtr'(pop);
            tail <= wrPtr + StorePkg::SqPtr'(push);
            count <= keepCnt + StorePkg::SqCnt'(push) - StorePkg::SqCnt'(pop);
            entryValid <= nextValid;
            // faulting stores retire silently
            memWrite.valid <= pop && !entries[head].exception;
            if (pop) begin
                memWrite.addr <= entries[head].addr;
                memWrite.data <= entries[head].data;
                memWrite.wmask <= entries[head].wmask;
                memWrite.cboOp <= (entries[head].wmask == '0) ? entries[head].data[1:0] : 2'b00;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) count <= StorePkg::SQ_DEPTH);

    // commit always refers to a store already sitting in the queue
    assert property (@(posedge clk) disable iff (rst) commit |-> count != '0);

endmodule

`default_nettype wire

/* rtl/StoreUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module StoreUnit (
    input logic clk,
    input logic rst,
    input StorePkg::ModeFlags mode,
    input logic [63:0] regionMask,
    input StorePkg::BranchProv branch,
    input StorePkg::StoreUop uop,
    input logic commit,
    output StorePkg::ResUop resUop,
    output StorePkg::MemWrite memWrite,
    output logic stall
);

    StorePkg::AguOp aguOp;

    StoreAgu agu (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .mode(mode),
        .regionMask(regionMask),
        .branch(branch),
        .uop(uop),
        .aguOp(aguOp),
        .resUop(resUop)
    );

    // full queue holds the AGU and the issuer
    StoreQueue queue (
        .clk(clk),
        .rst(rst),
        .aguOp(aguOp),
        .branch(branch),
        .commit(commit),
        .full(stall),
        .memWrite(memWrite)
    );

endmodule

`default_nettype wire

/* tb.f */
rtl/StorePkg.sv
rtl/StoreAgu.sv
rtl/StoreQueue.sv
rtl/StoreUnit.sv
verif/StoreChecker.sv
verif/StoreTb.sv

/* verif/StoreChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module StoreChecker (
    input logic clk,
    input logic rst,
    input StorePkg::ModeFlags mode,
    input logic [63:0] regionMask,
    input StorePkg::BranchProv branch,
    input StorePkg::StoreUop uop,
    input logic commit,
    input StorePkg::ResUop resUop,
    input StorePkg::MemWrite memWrite,
    input logic stall,
    output int qCount,
    output logic qFull,
    output logic pending,
    output int errors,
    output int checks
);

    // model state for after the next rising edge is computed on the falling edge
    StorePkg::AguOp aguReg;
    StorePkg::AguOp modelQ[$];
    StorePkg::ResUop expRes;
    StorePkg::MemWrite expMem;

    initial begin
        errors = 0;
        checks = 0;
        qCount = 0;
        qFull = 1'b0;
        pending = 1'b0;
    end

    function automatic logic newerThan(StorePkg::SqN a, StorePkg::SqN b);
        StorePkg::SqN diff;
        diff = a - b;
        return diff != '0 && !diff[6];
    endfunction

    function automatic logic [31:0] laneBits(StorePkg::ByteMask m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic void predict(input StorePkg::StoreUop u, output StorePkg::AguOp op,
                                    output StorePkg::ResUop res);
        StorePkg::Word sum;
        StorePkg::Word a;
        logic bad;
        sum = u.srcA + {{20{u.imm[11]}}, u.imm};
        a = (u.opcode inside {StorePkg::SB, StorePkg::SH, StorePkg::SW}) ? sum : u.srcA;
        bad = (a == 32'd0);
        if (u.opcode inside {StorePkg::SH, StorePkg::SH_I}) begin
            bad = bad || a[0];
        end else if (!(u.opcode inside {StorePkg::SB, StorePkg::SB_I})) begin
            bad = bad || (a[1:0] != 2'b00);
        end
        if (mode[StorePkg::MODE_NO_CREGS_WR] && a[31:24] == 8'hFF) begin
            bad = 1'b1;
        end
        if (mode[StorePkg::MODE_WMASK] && !regionMask[a[31:26]]) begin
            bad = 1'b1;
        end
        op = '0;
        op.valid = 1'b1;
        op.addr = a;
        op.data = u.srcB;
        op.wmask = 4'b1111;
        op.exception = bad;
        op.pc = u.pc;
        op.sqN = u.sqN;
        res = '0;
        res.valid = 1'b1;
        res.tagDst = u.tagDst;
        res.nmDst = u.nmDst;
        res.sqN = u.sqN;
        res.pc = u.pc;
        res.flags = StorePkg::NONE;
        res.result = sum;
        case (u.opcode)
            StorePkg::SB, StorePkg::SB_I: begin
                op.data = u.srcB << (8 * a[1:0]);
                op.wmask = 4'b0001 << a[1:0];
            end
            StorePkg::SH, StorePkg::SH_I: begin
                op.data = u.srcB << (16 * a[1]);
                op.wmask = a[1] ? 4'b1100 : 4'b0011;
            end
            StorePkg::SC_W: begin
                res.tagDst = StorePkg::TAG_DISCARD;
                res.nmDst = '0;
            end
            // cbo code rides in the low data bits
            StorePkg::CBO_CLEAN: begin
                op.wmask = '0;
                op.data = 32'd0;
            end
            StorePkg::CBO_INVAL: begin
                op.wmask = '0;
                op.data = 32'd1;
                res.flags = StorePkg::ORDERING;
            end
            StorePkg::CBO_FLUSH: begin
                op.wmask = '0;
                op.data = 32'd2;
                res.flags = StorePkg::ORDERING;
            end
            StorePkg::AMOADD: op.data = u.srcB + u.srcC;
            StorePkg::AMOXOR: op.data = u.srcB ^ u.srcC;
            StorePkg::AMOAND: op.data = u.srcB & u.srcC;
            StorePkg::AMOOR: op.data = u.srcB | u.srcC;
            StorePkg::AMOMIN: op.data = ($signed(u.srcB) < $signed(u.srcC)) ? u.srcB : u.srcC;
            StorePkg::AMOMAX: op.data = ($signed(u.srcB) > $signed(u.srcC)) ? u.srcB : u.srcC;
            StorePkg::AMOMINU: op.data = (u.srcB < u.srcC) ? u.srcB : u.srcC;
            StorePkg::AMOMAXU: op.data = (u.srcB > u.srcC) ? u.srcB : u.srcC;
            default: ;
        endcase
        if (bad) begin
            res.flags = StorePkg::ACCESS_FAULT;
        end
    endfunction

    task automatic checkField(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareOutputs();
        checkField("stall", 32'(qFull), 32'(stall));
        checkField("resUop.valid", 32'(expRes.valid), 32'(resUop.valid));
        if (expRes.valid && resUop.valid) begin
            checkField("resUop.tagDst", 32'(expRes.tagDst), 32'(resUop.tagDst));
            checkField("resUop.nmDst", 32'(expRes.nmDst), 32'(resUop.nmDst));
            checkField("resUop.sqN", 32'(expRes.sqN), 32'(resUop.sqN));
            checkField("resUop.pc", expRes.pc, resUop.pc);
            checkField("resUop.flags", 32'(expRes.flags), 32'(resUop.flags));
            checkField("resUop.result", expRes.result, resUop.result);
        end
        checkField("memWrite.valid", 32'(expMem.valid), 32'(memWrite.valid));
        if (expMem.valid && memWrite.valid) begin
            checkField("memWrite.addr", expMem.addr, memWrite.addr);
            checkField("memWrite.wmask", 32'(expMem.wmask), 32'(memWrite.wmask));
            checkField("memWrite.cboOp", 32'(expMem.cboOp), 32'(memWrite.cboOp));
            // only the written lanes matter
            checkField("memWrite.data", expMem.data & laneBits(expMem.wmask),
                memWrite.data & laneBits(expMem.wmask));
        end
    endtask

    task automatic stepModel();
        StorePkg::AguOp head;
        StorePkg::AguOp newOp;
        StorePkg::ResUop newRes;
        logic full;
        logic killHeld;
        logic push;
        full = (modelQ.size() == StorePkg::SQ_DEPTH);
        killHeld = aguReg.valid && branch.taken && newerThan(aguReg.sqN, branch.sqN);
        push = aguReg.valid && !full && !killHeld;
        if (branch.taken) begin
            while (modelQ.size() > 0 && newerThan(modelQ[$].sqN, branch.sqN)) begin
                void'(modelQ.pop_back());
            end
        end
        expMem = '0;
        if (commit && modelQ.size() > 0) begin
            head = modelQ.pop_front();
            if (!head.exception) begin
                expMem.valid = 1'b1;
                expMem.addr = head.addr;
                expMem.data = head.data;
                expMem.wmask = head.wmask;
                expMem.cboOp = (head.wmask == '0) ? head.data[1:0] : 2'b00;
            end
        end
        if (push) begin
            modelQ.push_back(aguReg);
        end
        expRes.valid = 1'b0;
        if (uop.valid && !full && !(branch.taken && newerThan(uop.sqN, branch.sqN))) begin
            predict(uop, newOp, newRes);
            aguReg = newOp;
            expRes = newRes;
        end else if (!full || killHeld) begin
            aguReg.valid = 1'b0;
        end
        qCount = modelQ.size();
        qFull = (qCount == StorePkg::SQ_DEPTH);
        pending = aguReg.valid || qCount != 0;
    endtask

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            aguReg = '0;
            modelQ.delete();
            expRes = '0;
            expMem = '0;
            qCount = 0;
            qFull = 1'b0;
            pending = 1'b0;
        end else begin
            compareOutputs();
            stepModel();
        end
    end

endmodule

`default_nettype wire

/* verif/StoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module StoreTb;

    localparam int CLK_PERIOD = 8;
    localparam int PHASES = 5;
    localparam int PHASE_CYCLES = 300;
    localparam int WATCHDOG_NS = PHASES * PHASE_CYCLES * CLK_PERIOD * 2;

    logic clk;
    logic rst;
    StorePkg::ModeFlags mode;
    logic [63:0] regionMask;
    StorePkg::BranchProv branch;
    StorePkg::StoreUop uop;
    logic commit;
    StorePkg::ResUop resUop;
    StorePkg::MemWrite memWrite;
    logic stall;
    int qCount;
    logic qFull;
    logic pending;
    int errors;
    int checks;
    logic [31:0] lfsr;
    StorePkg::SqN nextSqN;
    string phaseNames[PHASES] = '{"alignment and lanes", "faults", "atomics and special ops",
        "back-pressure", "branch flush"};

    StoreUnit DUT (
        .clk(clk),
        .rst(rst),
        .mode(mode),
        .regionMask(regionMask),
        .branch(branch),
        .uop(uop),
        .commit(commit),
        .resUop(resUop),
        .memWrite(memWrite),
        .stall(stall)
    );

    StoreChecker chk (
        .clk(clk),
        .rst(rst),
        .mode(mode),
        .regionMask(regionMask),
        .branch(branch),
        .uop(uop),
        .commit(commit),
        .resUop(resUop),
        .memWrite(memWrite),
        .stall(stall),
        .qCount(qCount),
        .qFull(qFull),
        .pending(pending),
        .errors(errors),
        .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic StorePkg::StoreUop makeUop(int phase, StorePkg::SqN sqN);
        StorePkg::StoreUop u;
        logic [2:0] bias;
        u.valid = 1'b1;
        case (phase)
            1: u.opcode = StorePkg::LsuOp'(5'(takeBits(3) % 6));
            2: u.opcode = StorePkg::LsuOp'(5'(takeBits(3) % 7));
            3: u.opcode = StorePkg::LsuOp'(5'(6 + takeBits(4) % 13));
            default: u.opcode = StorePkg::LsuOp'(5'(takeBits(5) % 19));
        endcase
        u.srcA = takeBits(32);
        u.srcB = takeBits(32);
        u.srcC = takeBits(32);
        u.imm = 12'(takeBits(12));
        u.pc = takeBits(32);
        u.tagDst = 7'(takeBits(7));
        u.nmDst = 5'(takeBits(5));
        u.sqN = sqN;
        bias = 3'(takeBits(3));
        // steer addresses toward zero, the 0xFF page or word alignment
        if (bias >= 3'd3 || (phase != 1 && bias == 3'd1)) begin
            u.srcA[1:0] = 2'b00;
            u.imm[1:0] = 2'b00;
        end
        if (phase != 1 && bias == 3'd1) begin
            u.srcA[31:24] = 8'hFF;
        end
        if (phase != 1 && bias == 3'd0) begin
            u.srcA = '0;
            u.imm = '0;
        end
        return u;
    endfunction

    task automatic driveCycle(int phase);
        if (phase == 2 && takeBits(5) == 0) begin
            mode <= StorePkg::ModeFlags'(takeBits(2));
        end
        commit <= (qCount != 0) && (takeBits(3) < ((phase >= 4) ? 1 : 4));
        if (phase == 5 && takeBits(4) == 0) begin
            branch <= '{1'b1, StorePkg::SqN'(nextSqN - 7'd1 - 7'(takeBits(3)))};
        end else begin
            branch <= '0;
        end
        if (!qFull && (phase >= 4 || takeBits(2) != 0)) begin
            uop <= makeUop(phase, nextSqN);
            nextSqN = nextSqN + 7'd1;
        end else begin
            uop.valid <= 1'b0;
        end
    endtask

    initial begin
        int chkStart;
        int errStart;
        rst = 1'b1;
        mode = '0;
        regionMask = '1;
        branch = '0;
        uop = '0;
        commit = 1'b0;
        lfsr = 32'h4042cb0b;
        nextSqN = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int p = 1; p <= PHASES; p++) begin
            chkStart = checks;
            errStart = errors;
            if (p == 1 || p == 3) begin
                mode <= '0;
                regionMask <= '1;
            end else begin
                mode <= StorePkg::ModeFlags'(takeBits(2));
                regionMask <= {takeBits(32), takeBits(32)} | {takeBits(32), takeBits(32)};
            end
            repeat (PHASE_CYCLES) begin
                @(posedge clk);
                driveCycle(p);
            end
            $display("phase %0d %s: %0d checks, %0d errors", p, phaseNames[p - 1],
                checks - chkStart, errors - errStart);
        end
        // stop issuing and retire what is left
        @(posedge clk);
        uop <= '0;
        branch <= '0;
        commit <= (qCount != 0);
        while (pending) begin
            @(posedge clk);
            commit <= (qCount != 0);
        end
        commit <= 1'b0;
        repeat (2) @(posedge clk);
        $display("totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
